// ==== snoop_pkg.sv ====
/*
 * snoop intake shared definitions
 * widths, the snq and ctcq entry payloads and the ctc snoop code
 */

package snoop_pkg;

  //====================
  // field widths
  //====================
  // physical address
  localparam int PA_WIDTH   = 40;
  // AC snoop type code
  localparam int SNP_TYPE_W = 4;
  // AC protection field
  localparam int PROT_W     = 3;
  // write buffer dependency mask
  localparam int WMB_DEP_W  = 8;

  // ctc decode fields
  localparam int CTC_TYPE_W = 6;
  // asid or va starts at address bit 16
  localparam int ASID_LSB   = 16;
  localparam int ASID_VA_W  = PA_WIDTH - ASID_LSB;

  // all ones snoop code marks a cache or tlb maintenance request
  localparam logic [SNP_TYPE_W-1:0] CTC_SNOOP_CODE = '1;

  //====================
  // entry payloads
  //====================
  // normal snoop, 47 bits
  typedef struct packed {
    logic [PA_WIDTH-1:0]   addr;
    logic [PROT_W-1:0]     prot;
    logic [SNP_TYPE_W-1:0] snoop;
  } snq_payload_t;

  // ctc request, 31 bits
  // ctc_type is addr[14:12], addr[6:5], addr[0]
  typedef struct packed {
    logic [CTC_TYPE_W-1:0] ctc_type;
    // second beat flag, addr[0]
    logic                  trans_2nd;
    logic [ASID_VA_W-1:0]  asid_va;
  } ctc_payload_t;

endpackage

// ==== snoop_entry_if.sv ====
/*
 * snoop entry queue link
 * create path from the arbiter, head status and pop back from one queue
 */

`timescale 1ns/1ns

interface snoop_entry_if #(
  parameter type PAYLOAD_T = logic [7:0],
  parameter int  DEPTH     = 6,
  parameter int  DEP_W     = 8
);

  // create side
  logic             create_en;
  PAYLOAD_T         create_payload;
  logic [DEP_W-1:0] create_mask;
  // queue status
  logic             full;
  logic             head_vld;
  logic             head_done;
  PAYLOAD_T         head_payload;
  // retire oldest entry
  logic             pop;

  modport arb (
    output create_en, create_payload, create_mask, pop,
    input  full, head_vld, head_done, head_payload
  );

  modport queue (
    input  create_en, create_payload, create_mask, pop,
    output full, head_vld, head_done, head_payload
  );

endinterface

// ==== snoop_entry_queue.sv ====
/*
 * in-order snoop entry queue
 * ring of entries with payload and dependency mask, one-hot oldest
 * pointer, entries retire from the head once their mask has cleared
 */

`timescale 1ns/1ns

module snoop_entry_queue #(
  parameter type PAYLOAD_T = logic [7:0],
  parameter int  DEPTH     = 6,
  parameter int  DEP_W     = 8
) (
  input  logic             snpcrtclk,
  input  logic             cpurst_b,
  snoop_entry_if.queue     q,
  input  logic [DEP_W-1:0] dep_release
);

  localparam int IDX_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  logic [DEPTH-1:0] vld_q;
  logic [DEPTH-1:0] oldest_q;
  logic [IDX_W-1:0] create_idx_q;
  PAYLOAD_T         payload_q [DEPTH];
  logic [DEP_W-1:0] mask_q    [DEPTH];
  PAYLOAD_T         head_payload;
  logic [DEP_W-1:0] head_mask;

  //====================
  // entry control
  //====================
  always_ff @(posedge snpcrtclk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      vld_q        <= '0;
      oldest_q     <= DEPTH'(1);
      create_idx_q <= '0;
      for (int i = 0; i < DEPTH; i++)
      begin
        mask_q[i] <= '0;
      end
    end
    else
    begin
      // binary create index, wraps at DEPTH-1
      if (q.create_en)
      begin
        if (create_idx_q == IDX_W'(DEPTH - 1))
          create_idx_q <= '0;
        else
          create_idx_q <= create_idx_q + 1'b1;
      end
      // oldest pointer rotates one place per pop
      if (q.pop)
        oldest_q <= (oldest_q << 1) | (oldest_q >> (DEPTH - 1));
      for (int i = 0; i < DEPTH; i++)
      begin
        if (q.create_en && (create_idx_q == IDX_W'(i)))
        begin
          vld_q[i]  <= 1'b1;
          // release in the create cycle already applies
          mask_q[i] <= q.create_mask & ~dep_release;
        end
        else
        begin
          if (q.pop && oldest_q[i])
            vld_q[i] <= 1'b0;
          // every release bit clears across all entries
          mask_q[i] <= mask_q[i] & ~dep_release;
        end
      end
    end
  end

  // payload storage
  always_ff @(posedge snpcrtclk)
  begin
    if (q.create_en)
      payload_q[create_idx_q] <= q.create_payload;
  end

  //====================
  // head status
  //====================
  // one-hot select of the oldest entry
  always_comb
  begin
    head_payload = '0;
    head_mask    = '0;
    for (int i = 0; i < DEPTH; i++)
    begin
      if (oldest_q[i])
      begin
        head_payload = payload_q[i];
        head_mask    = mask_q[i];
      end
    end
  end

  assign q.full         = &vld_q;
  assign q.head_vld     = |(vld_q & oldest_q);
  // no dependency left on the oldest
  assign q.head_done    = ~|head_mask;
  assign q.head_payload = head_payload;

endmodule

// ==== snoop_req_arbiter.sv ====
/*
 * snoop request arbiter
 * steers AC requests into the snq or the ctcq, keeps the create order
 * and returns CR responses strictly in that order
 */

`timescale 1ns/1ns

module snoop_req_arbiter import snoop_pkg::*; #(
  parameter int SNQ_DEPTH  = 6,
  parameter int CTCQ_DEPTH = 6
) (
  input  logic                  snpcrtclk,
  input  logic                  cpurst_b,
  // AC channel
  input  logic                  ac_valid,
  input  logic [PA_WIDTH-1:0]   ac_addr,
  input  logic [PROT_W-1:0]     ac_prot,
  input  logic [SNP_TYPE_W-1:0] ac_snoop,
  output logic                  ac_ready,
  input  logic                  lm_stall,
  // dependency sources at create
  input  logic [WMB_DEP_W-1:0]  wmb_depd,
  input  logic                  ctc_busy,
  // CR channel
  output logic                  cr_valid,
  output logic                  cr_is_ctc,
  output logic [PA_WIDTH-1:0]   cr_tag,
  input  logic                  cr_ready,
  // entry queues
  snoop_entry_if.arb            snq,
  snoop_entry_if.arb            ctcq,
  output logic                  ac_empty
);

  // every live entry owns one order slot
  localparam int COQ_DEPTH = SNQ_DEPTH + CTCQ_DEPTH;
  localparam int PTR_W     = (COQ_DEPTH > 1) ? $clog2(COQ_DEPTH) : 1;

  logic                 is_ctc_req;
  logic                 tgt_full;
  logic                 snq_create;
  logic                 ctc_create;
  logic [PTR_W-1:0]     coq_create_ptr_q;
  logic [PTR_W-1:0]     coq_pop_ptr_q;
  logic [COQ_DEPTH-1:0] coq_src_q;
  logic                 head_src;
  logic                 cr_fire;

  //====================
  // AC classification
  //====================
  assign is_ctc_req = (ac_snoop == CTC_SNOOP_CODE);
  // target queue of this request
  assign tgt_full   = is_ctc_req ? ctcq.full : snq.full;

  // low whenever ac_valid is low
  assign ac_ready   = ac_valid && !lm_stall && !tgt_full;
  assign snq_create = ac_ready && !is_ctc_req;
  assign ctc_create = ac_ready && is_ctc_req;

  // core idle hint
  assign ac_empty = !ac_valid && !snq.head_vld && !ctcq.head_vld;

  //====================
  // entry create
  //====================
  // snq entry, waits on write buffer
  assign snq.create_en            = snq_create;
  assign snq.create_payload.addr  = ac_addr;
  assign snq.create_payload.prot  = ac_prot;
  assign snq.create_payload.snoop = ac_snoop;
  assign snq.create_mask          = wmb_depd;

  // ctcq entry, waits on maintenance engine
  assign ctcq.create_en = ctc_create;
  // type from addr[14:12], addr[6:5], addr[0]
  assign ctcq.create_payload.ctc_type  = {ac_addr[14:12], ac_addr[6:5], ac_addr[0]};
  assign ctcq.create_payload.trans_2nd = ac_addr[0];
  assign ctcq.create_payload.asid_va   = ac_addr[PA_WIDTH-1:ASID_LSB];
  assign ctcq.create_mask              = ctc_busy;

  //====================
  // create order queue
  //====================
  // slot source bit: 0 snq, 1 ctcq
  always_ff @(posedge snpcrtclk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      coq_create_ptr_q <= '0;
      coq_src_q        <= '0;
    end
    else if (ac_ready)
    begin
      coq_src_q[coq_create_ptr_q] <= is_ctc_req;
      if (coq_create_ptr_q == PTR_W'(COQ_DEPTH - 1))
        coq_create_ptr_q <= '0;
      else
        coq_create_ptr_q <= coq_create_ptr_q + 1'b1;
    end
  end

  // pop pointer follows accepted responses
  always_ff @(posedge snpcrtclk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      coq_pop_ptr_q <= '0;
    else if (cr_fire)
    begin
      if (coq_pop_ptr_q == PTR_W'(COQ_DEPTH - 1))
        coq_pop_ptr_q <= '0;
      else
        coq_pop_ptr_q <= coq_pop_ptr_q + 1'b1;
    end
  end

  //====================
  // CR response
  //====================
  // stale source bit is harmless, the queue it picks is empty then
  assign head_src = coq_src_q[coq_pop_ptr_q];

  assign cr_valid  = head_src ? (ctcq.head_vld && ctcq.head_done)
                              : (snq.head_vld && snq.head_done);
  assign cr_is_ctc = head_src;
  // asid_va zero-extended for ctc
  assign cr_tag    = head_src ? {{ASID_LSB{1'b0}}, ctcq.head_payload.asid_va}
                              : snq.head_payload.addr;

  assign cr_fire  = cr_valid && cr_ready;
  // only the queue at the order head retires
  assign snq.pop  = cr_fire && !head_src;
  assign ctcq.pop = cr_fire && head_src;

endmodule

// ==== snoop_unit_top.sv ====
/*
 * snoop intake unit
 * AC request arbiter with a snoop queue and a ctc queue behind it
 */

`timescale 1ns/1ns

module snoop_unit_top import snoop_pkg::*; #(
  parameter int SNQ_DEPTH  = 6,
  parameter int CTCQ_DEPTH = 6
) (
  input  logic                  snpcrtclk,
  input  logic                  cpurst_b,
  // AC channel
  input  logic                  ac_valid,
  input  logic [PA_WIDTH-1:0]   ac_addr,
  input  logic [PROT_W-1:0]     ac_prot,
  input  logic [SNP_TYPE_W-1:0] ac_snoop,
  output logic                  ac_ready,
  input  logic                  lm_stall,
  // write buffer dependency
  input  logic [WMB_DEP_W-1:0]  wmb_depd,
  input  logic [WMB_DEP_W-1:0]  wmb_release,
  // maintenance engine
  input  logic                  ctc_busy,
  input  logic                  ctc_done,
  // CR channel
  output logic                  cr_valid,
  output logic                  cr_is_ctc,
  output logic [PA_WIDTH-1:0]   cr_tag,
  input  logic                  cr_ready,
  output logic                  ac_empty
);

  //====================
  // queue links
  //====================
  snoop_entry_if #(
    .PAYLOAD_T (snq_payload_t),
    .DEPTH     (SNQ_DEPTH),
    .DEP_W     (WMB_DEP_W)
  ) snq_if ();

  // ctcq tracks a single busy bit
  snoop_entry_if #(
    .PAYLOAD_T (ctc_payload_t),
    .DEPTH     (CTCQ_DEPTH),
    .DEP_W     (1)
  ) ctcq_if ();

  snoop_req_arbiter #(
    .SNQ_DEPTH  (SNQ_DEPTH),
    .CTCQ_DEPTH (CTCQ_DEPTH)
  ) arb0 (
    .snpcrtclk (snpcrtclk),
    .cpurst_b  (cpurst_b),
    .ac_valid  (ac_valid),
    .ac_addr   (ac_addr),
    .ac_prot   (ac_prot),
    .ac_snoop  (ac_snoop),
    .ac_ready  (ac_ready),
    .lm_stall  (lm_stall),
    .wmb_depd  (wmb_depd),
    .ctc_busy  (ctc_busy),
    .cr_valid  (cr_valid),
    .cr_is_ctc (cr_is_ctc),
    .cr_tag    (cr_tag),
    .cr_ready  (cr_ready),
    .snq       (snq_if.arb),
    .ctcq      (ctcq_if.arb),
    .ac_empty  (ac_empty)
  );

  //====================
  // entry queues
  //====================
  // snoop queue, released by write buffer
  snoop_entry_queue #(
    .PAYLOAD_T (snq_payload_t),
    .DEPTH     (SNQ_DEPTH),
    .DEP_W     (WMB_DEP_W)
  ) snq0 (
    .snpcrtclk   (snpcrtclk),
    .cpurst_b    (cpurst_b),
    .q           (snq_if.queue),
    .dep_release (wmb_release)
  );

  // ctc queue, released by ctc_done
  snoop_entry_queue #(
    .PAYLOAD_T (ctc_payload_t),
    .DEPTH     (CTCQ_DEPTH),
    .DEP_W     (1)
  ) ctcq0 (
    .snpcrtclk   (snpcrtclk),
    .cpurst_b    (cpurst_b),
    .q           (ctcq_if.queue),
    .dep_release (ctc_done)
  );

endmodule

// ==== tb_snoop_unit.sv ====
/*
 * snoop intake unit testbench
 * directed AC/CR tests checked against an in-order response model
 */

`timescale 1ns/1ns

module tb_snoop_unit import snoop_pkg::*; ();

  localparam int SNQ_DEPTH      = 6;
  localparam int CTCQ_DEPTH     = 6;
  localparam int TIMEOUT_CYCLES = 2000;

  logic                  snpcrtclk;
  logic                  cpurst_b;
  logic                  ac_valid;
  logic [PA_WIDTH-1:0]   ac_addr;
  logic [PROT_W-1:0]     ac_prot;
  logic [SNP_TYPE_W-1:0] ac_snoop;
  logic                  ac_ready;
  logic                  lm_stall;
  logic [WMB_DEP_W-1:0]  wmb_depd;
  logic [WMB_DEP_W-1:0]  wmb_release;
  logic                  ctc_busy;
  logic                  ctc_done;
  logic                  cr_valid;
  logic                  cr_is_ctc;
  logic [PA_WIDTH-1:0]   cr_tag;
  logic                  cr_ready;
  logic                  ac_empty;

  // expected responses as {is_ctc, tag}
  logic [PA_WIDTH:0] exp_q [$];
  // model occupancy per queue
  int                snq_cnt;
  int                ctc_cnt;
  int                cycle_cnt = 0;
  logic [16:0]       lfsr_q;

  snoop_unit_top #(
    .SNQ_DEPTH  (SNQ_DEPTH),
    .CTCQ_DEPTH (CTCQ_DEPTH)
  ) dut0 (
    .snpcrtclk   (snpcrtclk),
    .cpurst_b    (cpurst_b),
    .ac_valid    (ac_valid),
    .ac_addr     (ac_addr),
    .ac_prot     (ac_prot),
    .ac_snoop    (ac_snoop),
    .ac_ready    (ac_ready),
    .lm_stall    (lm_stall),
    .wmb_depd    (wmb_depd),
    .wmb_release (wmb_release),
    .ctc_busy    (ctc_busy),
    .ctc_done    (ctc_done),
    .cr_valid    (cr_valid),
    .cr_is_ctc   (cr_is_ctc),
    .cr_tag      (cr_tag),
    .cr_ready    (cr_ready),
    .ac_empty    (ac_empty)
  );

  //====================
  // clock and timeout
  //====================
  initial
  begin
    snpcrtclk = 1'b0;
    forever #2 snpcrtclk = ~snpcrtclk;
  end

  always @(posedge snpcrtclk)
  begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES)
    begin
      $display("timeout after %0d cycles, a handshake never completed", cycle_cnt);
      $display("TB FAILED");
      $fatal(1);
    end
  end

  //====================
  // helpers
  //====================
  // x^17 + x^14 + 1 stepped once per bit
  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      v      = {v[62:0], lfsr_q[16]};
      fb     = lfsr_q[16] ^ lfsr_q[13];
      lfsr_q = {lfsr_q[15:0], fb};
    end
    return v;
  endfunction

  // any type code but all ones
  function automatic logic [SNP_TYPE_W-1:0] rand_snoop();
    logic [63:0] r;
    r = rand_bits(SNP_TYPE_W);
    if (r[3:0] == 4'hF)
      return 4'h0;
    return r[3:0];
  endfunction

  // snq returns the address and ctc returns addr[39:16]
  function automatic logic [PA_WIDTH-1:0] expected_tag(input logic [PA_WIDTH-1:0] addr,
                                                       input logic is_ctc);
    if (is_ctc)
      return {16'h0000, addr[PA_WIDTH-1:16]};
    return addr;
  endfunction

  // ready only with no stall and room in the target queue
  function automatic logic expected_ready(input logic [SNP_TYPE_W-1:0] snp);
    if (lm_stall)
      return 1'b0;
    if (snp == 4'hF)
      return ctc_cnt < CTCQ_DEPTH;
    return snq_cnt < SNQ_DEPTH;
  endfunction

  task automatic report_fail(input string line);
    $display("%s", line);
    $display("TB FAILED");
    $fatal(1);
  endtask

  task automatic check_val(input string test, input string what,
                           input logic [63:0] exp, input logic [63:0] act);
    assert (act === exp)
    else report_fail($sformatf("mismatch %s %s expected %0h actual %0h",
                               test, what, exp, act));
  endtask

  // returns 1 ns after the next rising edge
  task automatic step();
    @(posedge snpcrtclk);
    #1;
  endtask

  task automatic check_empty(input string test, input logic exp);
    #1;
    check_val(test, "ac_empty", 64'(exp), 64'(ac_empty));
    step();
  endtask

  task automatic pulse_release(input logic [WMB_DEP_W-1:0] rel, input logic done);
    wmb_release = rel;
    ctc_done    = done;
    step();
    wmb_release = '0;
    ctc_done    = 1'b0;
  endtask

  //====================
  // AC and CR drivers
  //====================
  task automatic send_req(input string test, input logic [PA_WIDTH-1:0] addr,
                          input logic [SNP_TYPE_W-1:0] snp,
                          input logic [WMB_DEP_W-1:0] mask, input logic busy);
    logic [63:0] p;
    logic        is_ctc;
    p        = rand_bits(PROT_W);
    is_ctc   = (snp == 4'hF);
    ac_valid = 1'b1;
    ac_addr  = addr;
    ac_prot  = p[2:0];
    ac_snoop = snp;
    wmb_depd = mask;
    ctc_busy = busy;
    #1;
    check_val(test, "ac_ready", 64'(expected_ready(snp)), 64'(ac_ready));
    // transfer on this edge
    step();
    exp_q.push_back({is_ctc, expected_tag(addr, is_ctc)});
    if (is_ctc)
      ctc_cnt++;
    else
      snq_cnt++;
    ac_valid = 1'b0;
    wmb_depd = '0;
    ctc_busy = 1'b0;
  endtask

  // request offered and withdrawn before the edge
  task automatic probe_ready(input string test, input logic [PA_WIDTH-1:0] addr,
                             input logic [SNP_TYPE_W-1:0] snp, input logic exp);
    ac_valid = 1'b1;
    ac_addr  = addr;
    ac_snoop = snp;
    #1;
    check_val(test, "ac_ready", 64'(exp), 64'(ac_ready));
    ac_valid = 1'b0;
    #1;
    check_val(test, "ac_ready idle", 64'(0), 64'(ac_ready));
    step();
  endtask

  task automatic take_resp(input string test);
    logic [PA_WIDTH:0] e;
    cr_ready = 1'b1;
    #1;
    while (!cr_valid)
    begin
      step();
      #1;
    end
    e = exp_q.pop_front();
    check_val(test, "cr_is_ctc", 64'(e[PA_WIDTH]), 64'(cr_is_ctc));
    check_val(test, "cr_tag", 64'(e[PA_WIDTH-1:0]), 64'(cr_tag));
    step();
    cr_ready = 1'b0;
    if (e[PA_WIDTH])
      ctc_cnt--;
    else
      snq_cnt--;
  endtask

  // nothing may complete while the head is blocked
  task automatic idle_check(input string test, input int cycles);
    for (int i = 0; i < cycles; i++)
    begin
      #1;
      check_val(test, "cr_valid", 64'(0), 64'(cr_valid));
      step();
    end
  endtask

  // head held by cr_ready low
  task automatic hold_check(input string test, input int cycles);
    for (int i = 0; i < cycles; i++)
    begin
      #1;
      check_val(test, "cr_valid", 64'(1), 64'(cr_valid));
      check_val(test, "cr_tag", 64'(exp_q[0][PA_WIDTH-1:0]), 64'(cr_tag));
      step();
    end
  endtask

  //====================
  // directed tests
  //====================
  task automatic test_idle();
    check_empty("idle", 1'b1);
    send_req("idle", 40'h55_0000_1234, 4'h5, 8'h02, 1'b0);
    check_empty("idle", 1'b0);
    check_empty("idle", 1'b0);
    pulse_release(8'h02, 1'b0);
    take_resp("idle");
    check_empty("idle", 1'b1);
  endtask

  task automatic test_plain();
    logic [63:0] r;
    for (int i = 0; i < 5; i++)
    begin
      r = rand_bits(PA_WIDTH);
      send_req("plain", r[PA_WIDTH-1:0], rand_snoop(), 8'h00, 1'b0);
    end
    check_empty("plain", 1'b0);
    for (int i = 0; i < 5; i++)
      take_resp("plain");
    check_empty("plain", 1'b1);
  endtask

  // type and 2nd-trans bits set in various patterns
  task automatic test_ctc();
    send_req("ctc", 40'hA5_C3E1_7061, 4'hF, 8'h00, 1'b0);
    send_req("ctc", 40'h00_0001_0000, 4'hF, 8'h00, 1'b0);
    send_req("ctc", 40'hFF_FFFF_FFFF, 4'hF, 8'h00, 1'b0);
    send_req("ctc", 40'h3C_9A00_4021, 4'hF, 8'h00, 1'b0);
    for (int i = 0; i < 4; i++)
      take_resp("ctc");
    check_empty("ctc", 1'b1);
  endtask

  task automatic test_order();
    send_req("order", 40'h11_2233_4455, 4'h1, 8'h05, 1'b0);
    send_req("order", 40'h66_7788_0000, 4'hF, 8'h00, 1'b0);
    send_req("order", 40'h0A_0B0C_0D0E, 4'h2, 8'h00, 1'b0);
    send_req("order", 40'h99_AABB_0021, 4'hF, 8'h00, 1'b1);
    send_req("order", 40'h0F_EDCB_A987, 4'h3, 8'h10, 1'b0);
    // completed entries stay behind the oldest
    cr_ready = 1'b1;
    idle_check("order", 3);
    pulse_release(8'h01, 1'b0);
    idle_check("order", 2);
    pulse_release(8'h04, 1'b0);
    for (int i = 0; i < 3; i++)
      take_resp("order");
    // last snoop done early but waits on the busy ctc entry ahead
    cr_ready = 1'b1;
    pulse_release(8'h10, 1'b0);
    idle_check("order", 3);
    pulse_release(8'h00, 1'b1);
    take_resp("order");
    take_resp("order");
    check_empty("order", 1'b1);
  endtask

  task automatic test_full();
    logic [63:0] r;
    logic [63:0] m;
    for (int i = 0; i < SNQ_DEPTH; i++)
    begin
      r = rand_bits(PA_WIDTH);
      m = rand_bits(WMB_DEP_W);
      send_req("full", r[PA_WIDTH-1:0], rand_snoop(), m[7:0] | 8'h80, 1'b0);
    end
    probe_ready("full", 40'h12_3456_789A, 4'h4, 1'b0);
    send_req("full", 40'hC0_FFEE_1000, 4'hF, 8'h00, 1'b0);
    // stall blocks both targets
    lm_stall = 1'b1;
    probe_ready("full", 40'h12_3456_789A, 4'h4, 1'b0);
    probe_ready("full", 40'h21_0000_0003, 4'hF, 1'b0);
    lm_stall = 1'b0;
    idle_check("full", 2);
    pulse_release(8'hFF, 1'b0);
    for (int i = 0; i < SNQ_DEPTH + 1; i++)
      take_resp("full");
    check_empty("full", 1'b1);
  endtask

  task automatic test_backpressure();
    logic [63:0] r;
    for (int i = 0; i < 3; i++)
    begin
      r = rand_bits(PA_WIDTH);
      send_req("backpressure", r[PA_WIDTH-1:0], rand_snoop(), 8'h00, 1'b0);
    end
    hold_check("backpressure", 4);
    take_resp("backpressure");
    hold_check("backpressure", 2);
    take_resp("backpressure");
    hold_check("backpressure", 3);
    take_resp("backpressure");
    // nothing repeated
    idle_check("backpressure", 2);
    check_empty("backpressure", 1'b1);
  endtask

  //====================
  // main sequence
  //====================
  initial
  begin
    lfsr_q      = 17'd72256;
    snq_cnt     = 0;
    ctc_cnt     = 0;
    cpurst_b    = 1'b0;
    ac_valid    = 1'b0;
    ac_addr     = '0;
    ac_prot     = '0;
    ac_snoop    = '0;
    lm_stall    = 1'b0;
    wmb_depd    = '0;
    wmb_release = '0;
    ctc_busy    = 1'b0;
    ctc_done    = 1'b0;
    cr_ready    = 1'b0;
    repeat (2) @(posedge snpcrtclk);
    #1;
    cpurst_b = 1'b1;
    test_idle();
    test_plain();
    test_ctc();
    test_order();
    test_full();
    test_backpressure();
    $display("TB PASSED");
    $finish;
  end

endmodule

// ==== verilog.f ====
snoop_pkg.sv
snoop_entry_if.sv
snoop_entry_queue.sv
snoop_req_arbiter.sv
snoop_unit_top.sv
tb_snoop_unit.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the snoop unit testbench
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert \
  -f verilog.f \
  --top-module tb_snoop_unit \
  -o sim_snoop_unit
./obj_dir/sim_snoop_unit
